//--- decode_stage.sv
`timescale 1ns/10ps

module decode_stage (
    input  logic              clk,
    input  logic              rst,
    input  logic              stall,
    input  logic              flush,
    input  logic [31:0]       instr,
    input  logic [63:0]       pc_in,
    input  logic [63:0]       src1,
    input  logic [63:0]       src2,
    input  logic [5:0]        ex_load_rd,
    output logic [4:0]        rs1,
    output logic [4:0]        rs2,
    output logic              load_use,
    output rv_pkg::dec_ctrl_t dec_out
);
    import rv_pkg::*;

    logic        valid_q;
    logic [31:0] instr_q;
    logic [63:0] pc_q;
    logic [2:0]  funct3;
    logic [6:0]  funct7;
    logic [63:0] imm_i, imm_s, imm_b, imm_u, imm_j;
    logic        use_rs1, use_rs2, wr;
    dec_ctrl_t   dec;

    function automatic alu_op_e alu_sel(input logic [2:0] f3, input logic alt);
        case (f3)
            3'b000:  return alt ? alu_sub : alu_add;
            3'b001:  return alu_sll;
            3'b010:  return alu_slt;
            3'b011:  return alu_sltu;
            3'b100:  return alu_xor;
            3'b101:  return alt ? alu_sra : alu_srl;
            3'b110:  return alu_or;
            default: return alu_and;
        endcase
    endfunction

    always_ff @(posedge clk) begin
        if (!rst) begin
            valid_q <= 1'b0;
            instr_q <= nop_instr;
        end else if (!stall && !load_use) begin
            valid_q <= 1'b1;
            instr_q <= instr;
            pc_q    <= pc_in;
        end
    end

    assign funct3 = instr_q[14:12];
    assign funct7 = instr_q[31:25];
    assign rs1    = instr_q[19:15];
    assign rs2    = instr_q[24:20];

    assign imm_i = {{52{instr_q[31]}}, instr_q[31:20]};
    assign imm_s = {{52{instr_q[31]}}, instr_q[31:25], instr_q[11:7]};
    assign imm_b = {{52{instr_q[31]}}, instr_q[7], instr_q[30:25], instr_q[11:8], 1'b0};
    assign imm_u = {{32{instr_q[31]}}, instr_q[31:12], 12'd0};
    assign imm_j = {{44{instr_q[31]}}, instr_q[19:12], instr_q[20], instr_q[30:21], 1'b0};

    always_comb begin
        dec            = '0;
        dec.pc         = pc_q;
        dec.op_a       = src1;
        dec.op_b       = src2;
        dec.store_data = src2;
        dec.rd         = instr_q[11:7];
        dec.alu_op     = alu_add;
        dec.br_op      = br_none;
        use_rs1        = 1'b0;
        use_rs2        = 1'b0;
        wr             = 1'b0;
        case (opcode_e'(instr_q[6:0]))
            opc_op: begin
                use_rs1    = 1'b1;
                use_rs2    = 1'b1;
                wr         = 1'b1;
                dec.alu_op = alu_sel(funct3, funct7[5]);
                if (funct7 != 7'd0 && !(funct7 == 7'b0100000 &&
                    (funct3 == 3'b000 || funct3 == 3'b101))) begin
                    dec.illegal = 1'b1;
                end
            end
            opc_imm: begin
                use_rs1    = 1'b1;
                wr         = 1'b1;
                dec.op_b   = imm_i;
                dec.alu_op = alu_sel(funct3, funct3 == 3'b101 && instr_q[30]);
                // Six-bit shift amount leaves only bit 30 free
                if ((funct3 == 3'b001 && instr_q[31:26] != 6'd0) ||
                    (funct3 == 3'b101 && instr_q[31:26] != 6'd0 &&
                     instr_q[31:26] != 6'b010000)) begin
                    dec.illegal = 1'b1;
                end
            end
            opc_lui: begin
                wr         = 1'b1;
                dec.op_b   = imm_u;
                dec.alu_op = alu_pass_b;
            end
            opc_auipc: begin
                wr           = 1'b1;
                dec.op_b     = imm_u;
                dec.use_pc_a = 1'b1;
            end
            opc_jal: begin
                wr        = 1'b1;
                dec.imm   = imm_j;
                dec.br_op = br_jump;
            end
            opc_jalr: begin
                use_rs1   = 1'b1;
                wr        = 1'b1;
                dec.imm   = imm_i;
                dec.jalr  = 1'b1;
                dec.br_op = (funct3 == 3'b000) ? br_jump : br_none;
                dec.illegal = (funct3 != 3'b000);
            end
            opc_branch: begin
                use_rs1 = 1'b1;
                use_rs2 = 1'b1;
                dec.imm = imm_b;
                case (funct3)
                    3'b000:  dec.br_op = br_eq;
                    3'b001:  dec.br_op = br_ne;
                    3'b100:  dec.br_op = br_lt;
                    3'b101:  dec.br_op = br_ge;
                    3'b110:  dec.br_op = br_ltu;
                    3'b111:  dec.br_op = br_geu;
                    default: dec.illegal = 1'b1;
                endcase
            end
            opc_load: begin
                use_rs1     = 1'b1;
                dec.op_b    = imm_i;
                wr          = (funct3 == 3'b011);
                dec.mem_rd  = (funct3 == 3'b011);
                dec.illegal = (funct3 != 3'b011);
            end
            opc_store: begin
                use_rs1     = 1'b1;
                use_rs2     = 1'b1;
                dec.op_b    = imm_s;
                dec.mem_wr  = (funct3 == 3'b011);
                dec.illegal = (funct3 != 3'b011);
            end
            opc_system: begin
                // ebreak only
                dec.is_ebreak = (instr_q == 32'h0010_0073);
                dec.illegal   = (instr_q != 32'h0010_0073);
            end
            default: dec.illegal = 1'b1;
        endcase
        dec.reg_wr = wr && !dec.illegal && (dec.rd != 5'd0);
    end

    // Load result only exists one stage later
    assign load_use = valid_q && ex_load_rd[5] &&
                      ((use_rs1 && rs1 == ex_load_rd[4:0]) ||
                       (use_rs2 && rs2 == ex_load_rd[4:0]));

    always_comb begin
        dec_out       = dec;
        dec_out.valid = valid_q && !flush && !load_use;
    end

endmodule

//--- execute_stage.sv
`timescale 1ns/10ps

module execute_stage (
    input  logic              clk,
    input  logic              rst,
    input  logic              stall,
    input  rv_pkg::dec_ctrl_t dec_in,
    output rv_pkg::ex_res_t   ex_out,
    output rv_pkg::fwd_t      ex_fwd,
    output logic              redirect,
    output logic [63:0]       redirect_pc,
    output logic              mem_rd,
    output logic              mem_wr,
    output logic [63:0]       addr,
    output logic [63:0]       data_wr,
    output logic [7:0]        wr_mask
);
    import rv_pkg::*;

    dec_ctrl_t   ex_q;
    logic        halt_q, stop_now, taken;
    logic [63:0] alu_a, alu_res, link, target;

    // Nothing younger than ebreak or an illegal encoding may execute
    assign stop_now = ex_q.valid && (ex_q.illegal || ex_q.is_ebreak);

    always_ff @(posedge clk) begin
        if (!rst) begin
            ex_q.valid <= 1'b0;
            halt_q     <= 1'b0;
        end else if (!stall) begin
            ex_q       <= dec_in;
            ex_q.valid <= dec_in.valid && !halt_q && !stop_now;
            halt_q     <= halt_q || stop_now;
        end
    end

    assign alu_a = ex_q.use_pc_a ? ex_q.pc : ex_q.op_a;

    always_comb begin
        case (ex_q.alu_op)
            alu_sub:    alu_res = alu_a - ex_q.op_b;
            alu_and:    alu_res = alu_a & ex_q.op_b;
            alu_or:     alu_res = alu_a | ex_q.op_b;
            alu_xor:    alu_res = alu_a ^ ex_q.op_b;
            alu_slt:    alu_res = {63'd0, $signed(alu_a) < $signed(ex_q.op_b)};
            alu_sltu:   alu_res = {63'd0, alu_a < ex_q.op_b};
            alu_sll:    alu_res = alu_a << ex_q.op_b[5:0];
            alu_srl:    alu_res = alu_a >> ex_q.op_b[5:0];
            alu_sra:    alu_res = $signed(alu_a) >>> ex_q.op_b[5:0];
            alu_pass_b: alu_res = ex_q.op_b;
            default:    alu_res = alu_a + ex_q.op_b;
        endcase
    end

    always_comb begin
        case (ex_q.br_op)
            br_eq:   taken = (ex_q.op_a == ex_q.op_b);
            br_ne:   taken = (ex_q.op_a != ex_q.op_b);
            br_lt:   taken = ($signed(ex_q.op_a) < $signed(ex_q.op_b));
            br_ge:   taken = ($signed(ex_q.op_a) >= $signed(ex_q.op_b));
            br_ltu:  taken = (ex_q.op_a < ex_q.op_b);
            br_geu:  taken = (ex_q.op_a >= ex_q.op_b);
            br_jump: taken = 1'b1;
            default: taken = 1'b0;
        endcase
    end

    assign link   = ex_q.pc + 64'd4;
    assign target = ex_q.jalr ? ((ex_q.op_a + ex_q.imm) & ~64'd1) : ex_q.pc + ex_q.imm;

    assign redirect    = ex_q.valid && taken;
    assign redirect_pc = target;

    always_comb begin
        ex_out.valid     = ex_q.valid;
        ex_out.next_pc   = taken ? target : link;
        ex_out.value     = (ex_q.br_op == br_jump) ? link : alu_res;
        ex_out.rd        = ex_q.rd;
        ex_out.reg_wr    = ex_q.reg_wr;
        ex_out.mem_rd    = ex_q.mem_rd;
        ex_out.is_ebreak = ex_q.is_ebreak;
        ex_out.illegal   = ex_q.illegal;
    end

    // Loads forward from the result stage instead
    assign ex_fwd.valid = ex_q.valid && ex_q.reg_wr && !ex_q.mem_rd;
    assign ex_fwd.rd    = ex_q.rd;
    assign ex_fwd.value = ex_out.value;

    assign mem_rd  = ex_q.valid && ex_q.mem_rd;
    assign mem_wr  = ex_q.valid && ex_q.mem_wr;
    assign addr    = alu_res;
    assign data_wr = ex_q.store_data;
    assign wr_mask = 8'hff;

    a_one_strobe: assert property (
        @(posedge clk) disable iff (!rst) !(mem_rd && mem_wr)
    );

endmodule

//--- fetch_unit.sv
`timescale 1ns/10ps

module fetch_unit #(
    parameter logic [63:0] reset_pc = 64'h0
) (
    input  logic        clk,
    input  logic        rst,
    input  logic        stall,
    input  logic        redirect,
    input  logic [63:0] redirect_pc,
    output logic [63:0] pc
);

    logic [63:0] pc_q;

    // Taken branch in execute steers the fetch address in the same cycle
    assign pc = redirect ? redirect_pc : pc_q;

    always_ff @(posedge clk) begin
        if (!rst) begin
            pc_q <= reset_pc;
        end else if (!stall) begin
            pc_q <= pc + 64'd4;
        end
    end

    // Jump targets from execute must keep word alignment too
    a_pc_aligned: assert property (
        @(posedge clk) disable iff (!rst) pc[1:0] == 2'b00
    );

endmodule

//--- reg_file.sv
`timescale 1ns/10ps

module reg_file (
    input  logic          clk,
    input  logic          rst,
    input  logic [4:0]    rs1,
    input  logic [4:0]    rs2,
    input  rv_pkg::fwd_t  ex_fwd,
    input  rv_pkg::fwd_t  wb_fwd,
    output logic [63:0]   src1,
    output logic [63:0]   src2
);

    logic [63:0] regs [1:31];

    always_ff @(posedge clk) begin
        if (wb_fwd.valid && wb_fwd.rd != 5'd0) begin
            regs[wb_fwd.rd] <= wb_fwd.value;
        end
    end

    // Youngest producer wins
    always_comb begin
        if (ex_fwd.valid && ex_fwd.rd == rs1) begin
            src1 = ex_fwd.value;
        end else if (wb_fwd.valid && wb_fwd.rd == rs1) begin
            src1 = wb_fwd.value;
        end else begin
            src1 = (rs1 == 5'd0) ? 64'd0 : regs[rs1];
        end

        if (ex_fwd.valid && ex_fwd.rd == rs2) begin
            src2 = ex_fwd.value;
        end else if (wb_fwd.valid && wb_fwd.rd == rs2) begin
            src2 = wb_fwd.value;
        end else begin
            src2 = (rs2 == 5'd0) ? 64'd0 : regs[rs2];
        end
    end

    // No bypass source may ever target x0
    a_x0_zero: assert property (
        @(posedge clk) disable iff (!rst)
        ((rs1 == 5'd0) |-> (src1 == 64'd0)) and ((rs2 == 5'd0) |-> (src2 == 64'd0))
    );

endmodule

//--- result_stage.sv
`timescale 1ns/10ps

module result_stage (
    input  logic            clk,
    input  logic            rst,
    input  logic            stall,
    input  rv_pkg::ex_res_t ex_in,
    input  logic [63:0]     data_rd,
    output rv_pkg::fwd_t    wb_fwd,
    output logic            out_valid,
    output logic            done,
    output logic            error,
    output logic [63:0]     pc_nxt
);
    import rv_pkg::*;

    ex_res_t res_q;
    logic    retire, retired_q;

    // Retirement ends for good once the core has stopped
    assign retire = ex_in.valid && !done && !error;

    always_ff @(posedge clk) begin
        if (!rst) begin
            res_q.valid <= 1'b0;
            retired_q   <= 1'b0;
            done        <= 1'b0;
            error       <= 1'b0;
        end else begin
            // One pulse per instruction even while the pipeline holds
            retired_q <= !stall && retire;
            if (!stall) begin
                res_q       <= ex_in;
                res_q.valid <= retire;
                // Stall already covers data_valid so read data is good here
                if (ex_in.mem_rd) begin
                    res_q.value <= data_rd;
                end
                if (retire && ex_in.is_ebreak) begin
                    done <= 1'b1;
                end
                if (retire && ex_in.illegal) begin
                    error <= 1'b1;
                end
            end
        end
    end

    assign wb_fwd.valid = res_q.valid && res_q.reg_wr;
    assign wb_fwd.rd    = res_q.rd;
    assign wb_fwd.value = res_q.value;

    assign out_valid = retired_q;
    assign pc_nxt    = res_q.next_pc;

endmodule

//--- rv_core.sv
`timescale 1ns/10ps

module rv_core #(
    parameter logic [63:0] reset_pc = 64'h0
) (
    input  logic        clk,
    input  logic        rst,
    input  logic [31:0] instr_rd,
    input  logic        instr_valid,
    input  logic [63:0] data_rd,
    input  logic        data_valid,
    output logic [63:0] pc_rd,
    output logic        mem_rd,
    output logic        mem_wr,
    output logic [63:0] addr,
    output logic [63:0] data_wr,
    output logic [7:0]  wr_mask,
    output logic [63:0] pc_nxt,
    output logic        out_valid,
    output logic        done,
    output logic        error
);
    import rv_pkg::*;

    logic        stall, load_use, redirect;
    logic [63:0] redirect_pc, src1, src2;
    logic [4:0]  rs1, rs2;
    logic [5:0]  ex_load_rd;
    dec_ctrl_t   dec_ctrl;
    ex_res_t     ex_res;
    fwd_t        ex_fwd, wb_fwd;

    // Missing fetch or an unanswered data access holds the whole pipeline
    assign stall = !instr_valid || ((mem_rd || mem_wr) && !data_valid);

    assign ex_load_rd = {ex_res.valid && ex_res.mem_rd && ex_res.reg_wr, ex_res.rd};

    fetch_unit #(.reset_pc(reset_pc)) u_fetch (
        .clk(clk), .rst(rst), .stall(stall || load_use),
        .redirect(redirect), .redirect_pc(redirect_pc), .pc(pc_rd)
    );

    reg_file u_regs (
        .clk(clk), .rst(rst), .rs1(rs1), .rs2(rs2),
        .ex_fwd(ex_fwd), .wb_fwd(wb_fwd), .src1(src1), .src2(src2)
    );

    decode_stage u_decode (
        .clk(clk), .rst(rst), .stall(stall), .flush(redirect),
        .instr(instr_rd), .pc_in(pc_rd), .src1(src1), .src2(src2),
        .ex_load_rd(ex_load_rd), .rs1(rs1), .rs2(rs2),
        .load_use(load_use), .dec_out(dec_ctrl)
    );

    execute_stage u_execute (
        .clk(clk), .rst(rst), .stall(stall), .dec_in(dec_ctrl),
        .ex_out(ex_res), .ex_fwd(ex_fwd),
        .redirect(redirect), .redirect_pc(redirect_pc),
        .mem_rd(mem_rd), .mem_wr(mem_wr), .addr(addr),
        .data_wr(data_wr), .wr_mask(wr_mask)
    );

    result_stage u_result (
        .clk(clk), .rst(rst), .stall(stall), .ex_in(ex_res), .data_rd(data_rd),
        .wb_fwd(wb_fwd), .out_valid(out_valid), .done(done), .error(error),
        .pc_nxt(pc_nxt)
    );

endmodule

//--- rv_pkg.sv
package rv_pkg;

    // Major opcodes handled by the core
    typedef enum logic [6:0] {
        opc_op     = 7'b0110011,
        opc_imm    = 7'b0010011,
        opc_lui    = 7'b0110111,
        opc_auipc  = 7'b0010111,
        opc_jal    = 7'b1101111,
        opc_jalr   = 7'b1100111,
        opc_branch = 7'b1100011,
        opc_load   = 7'b0000011,
        opc_store  = 7'b0100011,
        opc_system = 7'b1110011
    } opcode_e;

    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_xor,
        alu_slt,
        alu_sltu,
        alu_sll,
        alu_srl,
        alu_sra,
        alu_pass_b
    } alu_op_e;

    typedef enum logic [2:0] {
        br_none,
        br_eq,
        br_ne,
        br_lt,
        br_ge,
        br_ltu,
        br_geu,
        br_jump
    } br_op_e;

    // Decode to execute
    typedef struct packed {
        logic        valid;
        logic [63:0] pc;
        logic [63:0] op_a;
        logic [63:0] op_b;
        logic [63:0] imm;
        alu_op_e     alu_op;
        br_op_e      br_op;
        logic        use_pc_a;
        logic        jalr;
        logic        mem_rd;
        logic        mem_wr;
        logic        reg_wr;
        logic [4:0]  rd;
        logic [63:0] store_data;
        logic        is_ebreak;
        logic        illegal;
    } dec_ctrl_t;

    // Execute to result
    typedef struct packed {
        logic        valid;
        logic [63:0] next_pc;
        logic [63:0] value;
        logic [4:0]  rd;
        logic        reg_wr;
        logic        mem_rd;
        logic        is_ebreak;
        logic        illegal;
    } ex_res_t;

    typedef struct packed {
        logic        valid;
        logic [4:0]  rd;
        logic [63:0] value;
    } fwd_t;

    // addi x0, x0, 0
    localparam logic [31:0] nop_instr = 32'h0000_0013;

endpackage

//--- src.f
rv_pkg.sv
fetch_unit.sv
reg_file.sv
decode_stage.sv
execute_stage.sv
result_stage.sv
rv_core.sv
tb_rv_core.sv

//--- tb_rv_core.sv
`timescale 1ns/10ps

module tb_rv_core;

    // Longest program runs a few hundred cycles with waits and gaps
    localparam int test_cycle_limit = 2000;

    logic        clk, rst, instr_valid, data_valid;
    logic [31:0] instr_rd;
    logic [63:0] data_rd, pc_rd, addr, data_wr, pc_nxt;
    logic        mem_rd, mem_wr, out_valid, done, error;
    logic [7:0]  wr_mask;

    logic [31:0]  imem [0:63];
    logic [63:0]  dmem [0:255];
    logic [63:0]  mdm [0:255];
    logic [63:0]  act_pc[$], exp_pc[$];
    logic [127:0] act_st[$], exp_st[$];
    logic         exp_done, exp_err, gaps, armed, stall_tb;
    int           wp, errors, checks, cycles, wait_left;
    int           act_ld, exp_ld;
    string        cur_test;
    integer       seed = 32'h4896_5c6f;

    rv_core #(.reset_pc(64'h0)) u_dut (
        .clk(clk), .rst(rst), .instr_rd(instr_rd), .instr_valid(instr_valid),
        .data_rd(data_rd), .data_valid(data_valid), .pc_rd(pc_rd),
        .mem_rd(mem_rd), .mem_wr(mem_wr), .addr(addr), .data_wr(data_wr),
        .wr_mask(wr_mask), .pc_nxt(pc_nxt), .out_valid(out_valid),
        .done(done), .error(error)
    );

    assign instr_rd = imem[pc_rd[7:2]];
    assign data_rd  = dmem[addr[10:3]];
    assign stall_tb = !instr_valid || ((mem_rd || mem_wr) && !data_valid);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles > test_cycle_limit) begin
            $display("Timeout: program did not finish within %0d cycles", test_cycle_limit);
            $display("Checks failed");
            $finish;
        end
    end

    // Fetch gaps and data wait states
    initial begin
        integer      r;
        int unsigned u;
        forever begin
            @(posedge clk);
            #2;
            r = $random(seed);
            instr_valid = gaps ? (r[1:0] != 2'b00) : 1'b1;
            if (rst !== 1'b1 || !(mem_rd === 1'b1 || mem_wr === 1'b1)) begin
                data_valid = 1'b0;
                armed      = 1'b0;
            end else if (!armed) begin
                u          = $random(seed);
                armed      = 1'b1;
                wait_left  = u % 3;
                data_valid = (wait_left == 0);
            end else if (!data_valid) begin
                wait_left  = wait_left - 1;
                data_valid = (wait_left == 0);
            end
        end
    end

    // Retirements and stores, sampled mid-cycle
    always @(negedge clk) begin
        if (rst === 1'b1 && out_valid === 1'b1) begin
            act_pc.push_back(pc_nxt);
        end
        if (rst === 1'b1 && stall_tb === 1'b0) begin
            if (mem_wr) begin
                checks = checks + 1;
                if (wr_mask !== 8'hff) begin
                    errors = errors + 1;
                    $display("FAIL %s wr_mask expected %h actual %h",
                             cur_test, 8'hff, wr_mask);
                end
                act_st.push_back({addr, data_wr});
                dmem[addr[10:3]] = data_wr;
            end
            if (mem_rd) begin
                act_ld = act_ld + 1;
            end
            if (mem_rd || mem_wr) begin
                armed = 1'b0;
            end
        end
    end

    function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3,
                                          input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, 7'h33};
    endfunction

    function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                          input logic [2:0] f3, input logic [4:0] rd,
                                          input logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] enc_sd(input logic [4:0] rs2, input logic [11:0] imm);
        return {imm[11:5], rs2, 5'd0, 3'b011, imm[4:0], 7'h23};
    endfunction

    function automatic logic [31:0] enc_b(input logic [2:0] f3, input logic [4:0] rs1,
                                          input logic [4:0] rs2, input logic [12:0] imm);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'h63};
    endfunction

    function automatic logic [63:0] fill_word(input int i);
        logic [31:0] a;
        a = i * 8;
        return {a * 32'h9e37_79b9, ~a};
    endfunction

    function automatic logic [63:0] isa_alu(input logic [2:0] f3, input logic alt,
                                            input logic [63:0] a, input logic [63:0] b);
        case (f3)
            3'd0: return alt ? a - b : a + b;
            3'd1: return a << b[5:0];
            3'd2: return {63'd0, $signed(a) < $signed(b)};
            3'd3: return {63'd0, a < b};
            3'd4: return a ^ b;
            3'd5: begin
                if (alt) return $signed(a) >>> b[5:0];
                return a >> b[5:0];
            end
            3'd6: return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic logic isa_taken(input logic [2:0] f3, input logic [63:0] a,
                                       input logic [63:0] b);
        case (f3)
            3'd0: return a == b;
            3'd1: return a != b;
            3'd4: return $signed(a) < $signed(b);
            3'd5: return $signed(a) >= $signed(b);
            3'd6: return a < b;
            default: return a >= b;
        endcase
    endfunction

    task automatic put(input logic [31:0] w);
        imem[wp] = w;
        wp = wp + 1;
    endtask

    task automatic clear_program();
        for (int i = 0; i < 64; i++) imem[i] = 32'h0000_0013;
        wp = 0;
    endtask

    // Architectural model of the program in imem
    task automatic model_run();
        logic [63:0] x [0:31];
        logic [63:0] pc, npc, a, b, r, ia, ea;
        logic [31:0] ins;
        logic [2:0]  f3;
        logic        wr, stop;
        int          n;
        for (int i = 0; i < 32; i++) x[i] = 64'd0;
        for (int i = 0; i < 256; i++) mdm[i] = fill_word(i);
        exp_pc.delete();
        exp_st.delete();
        exp_ld   = 0;
        exp_done = 1'b0;
        exp_err  = 1'b0;
        pc = 64'd0;
        stop = 1'b0;
        n = 0;
        while (!stop && n < 1000) begin
            ins = imem[pc[7:2]];
            f3  = ins[14:12];
            a   = x[ins[19:15]];
            b   = x[ins[24:20]];
            ia  = {{52{ins[31]}}, ins[31:20]};
            npc = pc + 64'd4;
            wr  = 1'b1;
            r   = 64'd0;
            n   = n + 1;
            case (ins[6:0])
                7'h33: r = isa_alu(f3, ins[30], a, b);
                7'h13: r = isa_alu(f3, f3 == 3'd5 && ins[30], a, ia);
                7'h37: r = {{32{ins[31]}}, ins[31:12], 12'd0};
                7'h17: r = pc + {{32{ins[31]}}, ins[31:12], 12'd0};
                7'h6f: begin
                    r   = pc + 64'd4;
                    npc = pc + {{44{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
                end
                7'h67: begin
                    r   = pc + 64'd4;
                    npc = (a + ia) & ~64'd1;
                end
                7'h63: begin
                    wr = 1'b0;
                    if (isa_taken(f3, a, b))
                        npc = pc + {{52{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
                end
                7'h03: begin
                    ea     = a + ia;
                    r      = mdm[ea[10:3]];
                    exp_ld = exp_ld + 1;
                end
                7'h23: begin
                    wr = 1'b0;
                    ea = a + {{52{ins[31]}}, ins[31:25], ins[11:7]};
                    mdm[ea[10:3]] = b;
                    exp_st.push_back({ea, b});
                end
                default: begin
                    wr   = 1'b0;
                    stop = 1'b1;
                    if (ins == 32'h0010_0073) exp_done = 1'b1;
                    else exp_err = 1'b1;
                end
            endcase
            exp_pc.push_back(npc);
            if (wr && ins[11:7] != 5'd0) x[ins[11:7]] = r;
            pc = npc;
        end
    endtask

    task automatic check_value(input string name, input string what,
                               input logic [127:0] exp, input logic [127:0] act);
        checks = checks + 1;
        if (exp !== act) begin
            errors = errors + 1;
            $display("FAIL %s %s expected %h actual %h", name, what, exp, act);
        end
    endtask

    task automatic run_program(input string name, input logic with_gaps);
        model_run();
        for (int i = 0; i < 256; i++) dmem[i] = fill_word(i);
        cur_test = name;
        @(posedge clk);
        #2;
        rst  = 1'b0;
        gaps = with_gaps;
        repeat (3) @(posedge clk);
        #2;
        act_pc.delete();
        act_st.delete();
        act_ld = 0;
        cycles = 0;
        rst = 1'b1;
        do @(negedge clk); while (!(done || error));
        // The last retirement pulse coincides with done or error
        @(negedge clk);
        repeat (5) begin
            @(negedge clk);
            checks = checks + 1;
            if (out_valid) begin
                errors = errors + 1;
                $display("%s: out_valid rose after the core stopped", name);
            end
        end
        check_value(name, "done", exp_done, done);
        check_value(name, "error", exp_err, error);
        check_value(name, "retire count", exp_pc.size(), act_pc.size());
        check_value(name, "store count", exp_st.size(), act_st.size());
        check_value(name, "load count", exp_ld, act_ld);
        for (int i = 0; i < exp_pc.size() && i < act_pc.size(); i++)
            check_value(name, $sformatf("pc_nxt[%0d]", i), exp_pc[i], act_pc[i]);
        for (int i = 0; i < exp_st.size() && i < act_st.size(); i++)
            check_value(name, $sformatf("store[%0d]", i), exp_st[i], act_st[i]);
    endtask

    task automatic alu_chain();
        clear_program();
        put(enc_i(12'h123, 5'd0, 3'd0, 5'd1, 7'h13));
        put({20'h12345, 5'd2, 7'h37});
        put(enc_i(12'h988, 5'd2, 3'd0, 5'd2, 7'h13));
        put(enc_r(7'h00, 5'd2, 5'd1, 3'd0, 5'd3));
        put(enc_r(7'h20, 5'd1, 5'd3, 3'd0, 5'd4));
        put(enc_r(7'h00, 5'd3, 5'd4, 3'd4, 5'd5));
        put(enc_r(7'h00, 5'd1, 5'd5, 3'd6, 5'd6));
        put(enc_r(7'h00, 5'd2, 5'd6, 3'd7, 5'd7));
        put(enc_i(12'd13, 5'd7, 3'd1, 5'd8, 7'h13));
        put(enc_r(7'h00, 5'd1, 5'd8, 3'd1, 5'd9));
        put(enc_i(12'd7, 5'd9, 3'd5, 5'd10, 7'h13));
        put(enc_r(7'h20, 5'd9, 5'd0, 3'd0, 5'd12));
        put(enc_i(12'h405, 5'd12, 3'd5, 5'd13, 7'h13));
        put(enc_r(7'h20, 5'd1, 5'd12, 3'd5, 5'd14));
        put(enc_r(7'h00, 5'd1, 5'd12, 3'd5, 5'd15));
        put(enc_r(7'h00, 5'd1, 5'd12, 3'd2, 5'd16));
        put(enc_r(7'h00, 5'd1, 5'd12, 3'd3, 5'd17));
        put(enc_i(12'hfff, 5'd12, 3'd2, 5'd18, 7'h13));
        put(enc_i(12'h200, 5'd1, 3'd3, 5'd19, 7'h13));
        put({20'h00001, 5'd20, 7'h17});
        put(enc_i(12'h5a5, 5'd20, 3'd4, 5'd11, 7'h13));
        for (int k = 1; k <= 20; k++) put(enc_sd(k[4:0], 12'h400 + k * 8));
        put(32'h0010_0073);
        run_program("alu", 1'b0);
    endtask

    task automatic load_control_program();
        clear_program();
        // x5 is otherwise written only on paths that must be skipped
        put(enc_i(12'd0, 5'd0, 3'd0, 5'd5, 7'h13));
        put(enc_i(12'd5, 5'd0, 3'd0, 5'd1, 7'h13));
        put(enc_i(12'd0, 5'd0, 3'd0, 5'd2, 7'h13));
        put(enc_i(12'd3, 5'd2, 3'd0, 5'd2, 7'h13));
        put(enc_i(12'hfff, 5'd1, 3'd0, 5'd1, 7'h13));
        put(enc_b(3'd1, 5'd1, 5'd0, -13'sd8));
        put(enc_i(12'hffe, 5'd0, 3'd0, 5'd3, 7'h13));
        put(enc_i(12'd2, 5'd0, 3'd0, 5'd4, 7'h13));
        put(enc_b(3'd4, 5'd3, 5'd4, 13'd8));
        put(enc_i(12'd99, 5'd0, 3'd0, 5'd5, 7'h13));
        put(enc_b(3'd5, 5'd3, 5'd4, 13'd8));
        put(enc_b(3'd6, 5'd3, 5'd4, 13'd8));
        put(enc_b(3'd7, 5'd3, 5'd4, 13'd8));
        put(enc_i(12'd77, 5'd0, 3'd0, 5'd5, 7'h13));
        put(enc_b(3'd0, 5'd1, 5'd0, 13'd8));
        put(enc_i(12'd55, 5'd0, 3'd0, 5'd5, 7'h13));
        put({1'b0, 10'd6, 1'b0, 8'd0, 5'd6, 7'h6f});
        put(enc_i(12'd44, 5'd0, 3'd0, 5'd5, 7'h13));
        put(enc_i(12'd33, 5'd0, 3'd0, 5'd5, 7'h13));
        put({20'd0, 5'd7, 7'h17});
        put(enc_i(12'd16, 5'd7, 3'd0, 5'd7, 7'h13));
        put(enc_i(12'd0, 5'd7, 3'd0, 5'd8, 7'h67));
        put(enc_i(12'd22, 5'd0, 3'd0, 5'd5, 7'h13));
        put(enc_i(12'd0, 5'd0, 3'd0, 5'd9, 7'h13));
        put(enc_i(12'd3, 5'd0, 3'd0, 5'd10, 7'h13));
        put(enc_i(12'd1, 5'd9, 3'd0, 5'd9, 7'h13));
        put(enc_b(3'd4, 5'd9, 5'd10, -13'sd4));
        put(enc_sd(5'd2, 12'h400));
        put(enc_sd(5'd5, 12'h408));
        put(enc_sd(5'd6, 12'h410));
        put(enc_sd(5'd8, 12'h418));
        put(enc_sd(5'd9, 12'h420));
        put(enc_sd(5'd7, 12'h428));
        put(32'h0010_0073);
    endtask

    task automatic control_flow();
        load_control_program();
        run_program("control", 1'b0);
    endtask

    task automatic load_store();
        clear_program();
        put(enc_i(12'h111, 5'd0, 3'd0, 5'd1, 7'h13));
        put(enc_i(12'd40, 5'd1, 3'd1, 5'd1, 7'h13));
        put(enc_sd(5'd1, 12'h500));
        put(enc_i(12'h500, 5'd0, 3'd3, 5'd2, 7'h03));
        put(enc_i(12'd1, 5'd2, 3'd0, 5'd3, 7'h13));
        put(enc_sd(5'd3, 12'h508));
        put(enc_i(12'h508, 5'd0, 3'd3, 5'd4, 7'h03));
        put(enc_r(7'h00, 5'd4, 5'd4, 3'd0, 5'd5));
        put(enc_sd(5'd5, 12'h510));
        put(enc_i(12'h600, 5'd0, 3'd3, 5'd6, 7'h03));
        put(enc_r(7'h00, 5'd1, 5'd6, 3'd4, 5'd7));
        put(enc_sd(5'd7, 12'h518));
        put(enc_i(12'h518, 5'd0, 3'd3, 5'd8, 7'h03));
        put(enc_sd(5'd8, 12'h520));
        put(32'h0010_0073);
        run_program("mem", 1'b0);
    endtask

    task automatic fetch_gaps();
        load_control_program();
        run_program("fetch_gaps", 1'b1);
    endtask

    task automatic termination();
        clear_program();
        put(enc_i(12'd7, 5'd0, 3'd0, 5'd1, 7'h13));
        put(enc_sd(5'd1, 12'h400));
        put(32'h0010_0073);
        put(enc_sd(5'd1, 12'h408));
        run_program("ebreak", 1'b0);
        clear_program();
        put(enc_i(12'd9, 5'd0, 3'd0, 5'd1, 7'h13));
        put(enc_sd(5'd1, 12'h400));
        put(32'h0000_0000);
        put(enc_sd(5'd1, 12'h408));
        put(32'h0010_0073);
        run_program("illegal", 1'b0);
    endtask

    initial begin
        rst         = 1'b0;
        instr_valid = 1'b0;
        data_valid  = 1'b0;
        gaps        = 1'b0;
        armed       = 1'b0;
        errors      = 0;
        checks      = 0;
        cycles      = 0;
        act_ld      = 0;
        exp_ld      = 0;
        cur_test    = "";
        alu_chain();
        control_flow();
        load_store();
        fetch_gaps();
        termination();
        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule
